// ==== hw/cache_consts.svh ====
// address, index and tag widths and the backing memory latency
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// word address into the backing memory
`define CACHE_ADDR_W 12

// direct mapped, one word per line
`define CACHE_IDX_W 4                                  // 16 lines

// upper address bits kept per line
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_IDX_W)     // 8 bits

// cycles from memory start to done, must be 1 or more
`define MEM_LATENCY 4

`endif

// ==== hw/cache_pkg.sv ====
// word, address, tag, line and controller state types plus the byte merge function
`include "cache_consts.svh"

package cache_pkg;

    typedef logic [31:0]              word_t;
    typedef logic [`CACHE_ADDR_W-1:0] addr_t;
    typedef logic [`CACHE_TAG_W-1:0]  tag_t;

    typedef struct packed {
        logic  valid;                   // line holds real data
        tag_t  tag;                     // upper address bits
        word_t data;                    // cached word
    } line_t;                           // 41 bits

    typedef enum logic [2:0] {
        IDLE,                           // waiting for a request
        LOOKUP,                         // hit check, write hit update
        FILL,                           // read miss, memory read
        WRITE,                          // write through to memory
        DONE                            // ack held until req drops
    } fsm_state_t;

    // take new bytes where mask is set, keep old ones elsewhere
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, logic [3:0] mask);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

// ==== hw/word_ram.sv ====
// single port RAM, synchronous write and combinational read, entry type set by parameter
`timescale 1ns/1ps

module word_ram #(
    parameter type entry_t = logic [31:0],     // stored payload
    parameter int  DEPTH   = 256               // number of entries
) (
    input  logic                     CLK,
    input  logic                     i_we,     // write at rising edge
    input  logic [$clog2(DEPTH)-1:0] i_addr,   // shared read/write address
    input  entry_t                   i_wdata,
    output entry_t                   o_rdata   // async read of i_addr
);

    entry_t mem [DEPTH];                       // storage array

    // block RAM style power-up contents
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;                       // all zero at start
        end
    end

    always_ff @(posedge CLK) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;            // one entry per cycle
        end
    end

    assign o_rdata = mem[i_addr];              // read old data during a write

endmodule

// ==== hw/line_lookup.sv ====
// cache array with valid, tag and data, address split, hit compare and reset sweep
`timescale 1ns/1ps
`include "cache_consts.svh"

module line_lookup (
    input  logic              CLK,
    input  logic              rst_x,
    input  cache_pkg::addr_t  i_addr,    // request address, held by requester
    input  logic              i_we,      // line write from controller
    input  cache_pkg::line_t  i_wline,   // line to store at i_addr index
    output logic              o_hit,     // valid and tag match
    output cache_pkg::word_t  o_rdata    // word of the indexed line
);

    localparam int LINES = 2 ** `CACHE_IDX_W;

    logic [`CACHE_IDX_W-1:0] w_idx;          // line select
    cache_pkg::tag_t         w_tag;          // compare value
    logic [`CACHE_IDX_W-1:0] r_sweep = '0;   // clear pointer, runs only in reset
    logic [`CACHE_IDX_W-1:0] ram_addr;
    logic                    ram_we;
    cache_pkg::line_t        ram_wline;
    cache_pkg::line_t        ram_rline;

    assign {w_tag, w_idx} = i_addr;          // tag on top, index below

    // one line cleared per cycle, 16 reset cycles cover all lines
    always_ff @(posedge CLK) begin
        if (!rst_x) begin
            r_sweep <= r_sweep + 1'b1;       // wraps after the last line
        end
    end

    assign ram_we    = !rst_x || i_we;                 // sweep writes during reset
    assign ram_addr  = rst_x ? w_idx : r_sweep;
    assign ram_wline = rst_x ? i_wline : '0;           // zero line drops valid

    word_ram #(
        .entry_t (cache_pkg::line_t),
        .DEPTH   (LINES)
    ) u_lines (
        .CLK     (CLK),
        .i_we    (ram_we),
        .i_addr  (ram_addr),
        .i_wdata (ram_wline),
        .o_rdata (ram_rline)
    );

    assign o_hit   = ram_rline.valid && (ram_rline.tag == w_tag);
    assign o_rdata = ram_rline.data;         // meaningful only with o_hit

endmodule

// ==== hw/mem_wait_timer.sv ====
// down counter that paces the backing memory access latency
`timescale 1ns/1ps
`include "cache_consts.svh"

module mem_wait_timer (
    input  logic CLK,
    input  logic rst_x,
    input  logic i_start,   // start request, seen when idle
    output logic o_done     // one cycle, MEM_LATENCY cycles after start
);

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    logic [CNT_W-1:0] r_cnt;     // remaining cycles before done
    logic             r_busy;    // a run is in progress

    always_ff @(posedge CLK or negedge rst_x) begin
        if (!rst_x) begin
            r_cnt  <= '0;
            r_busy <= 1'b0;
        end else if (!r_busy) begin
            if (i_start) begin
                r_cnt  <= CNT_W'(`MEM_LATENCY - 1);  // start cycle counts as one
                r_busy <= 1'b1;
            end
        end else if (r_cnt == '0) begin
            r_busy <= 1'b0;                          // done cycle ends the run
        end else begin
            r_cnt <= r_cnt - 1'b1;                   // start ignored meanwhile
        end
    end

    // high for the last busy cycle only
    assign o_done = r_busy && (r_cnt == '0);

endmodule

// ==== hw/backing_mem.sv ====
// behavioral word memory with byte masked writes behind a four phase req/ack port
`timescale 1ns/1ps
`include "cache_consts.svh"

module backing_mem (
    input  logic             CLK,
    input  logic             rst_x,
    input  logic             i_req,     // held until o_ack seen
    input  logic             i_we,      // write when high, read otherwise
    input  cache_pkg::addr_t i_addr,
    input  cache_pkg::word_t i_wdata,
    input  logic [3:0]       i_mask,    // byte enables for writes
    output logic             o_ack,     // held until i_req falls
    output cache_pkg::word_t o_rdata    // read word, valid with o_ack
);

    localparam int DEPTH = 2 ** `CACHE_ADDR_W;

    logic             r_req_d;      // i_req one cycle back
    logic             tmr_start;
    logic             tmr_done;
    logic             ram_we;
    cache_pkg::word_t ram_wdata;
    cache_pkg::word_t ram_rdata;

    assign tmr_start = i_req && !r_req_d;          // rising request only

    mem_wait_timer u_timer (
        .CLK     (CLK),
        .rst_x   (rst_x),
        .i_start (tmr_start),
        .o_done  (tmr_done)
    );

    // read modify write in the done cycle
    assign ram_we    = tmr_done && i_we;
    assign ram_wdata = cache_pkg::merge_bytes(ram_rdata, i_wdata, i_mask);

    word_ram #(
        .entry_t (cache_pkg::word_t),
        .DEPTH   (DEPTH)
    ) u_words (
        .CLK     (CLK),
        .i_we    (ram_we),
        .i_addr  (i_addr),
        .i_wdata (ram_wdata),
        .o_rdata (ram_rdata)
    );

    always_ff @(posedge CLK or negedge rst_x) begin
        if (!rst_x) begin
            r_req_d <= 1'b0;
            o_ack   <= 1'b0;
        end else begin
            r_req_d <= i_req;
            if (tmr_done) begin
                o_ack <= 1'b1;            // access finished
            end else if (!i_req) begin
                o_ack <= 1'b0;            // requester released
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (tmr_done && !i_we) begin
            o_rdata <= ram_rdata;         // held through the ack phase
        end
    end

endmodule

// ==== hw/cache_fsm.sv ====
// cache controller FSM for lookup, fill, write through and both handshakes
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_fsm (
    input  logic              CLK,
    input  logic              rst_x,
    input  logic              i_req,         // requester handshake
    input  logic              i_we,
    input  cache_pkg::addr_t  i_addr,
    input  cache_pkg::word_t  i_wdata,
    input  logic [3:0]        i_mask,
    input  logic              i_hit,         // from cache array
    input  cache_pkg::word_t  i_cword,
    input  logic              i_mem_ack,     // memory handshake
    input  cache_pkg::word_t  i_mem_rdata,
    output logic              o_line_we,     // cache array update
    output cache_pkg::line_t  o_wline,
    output logic              o_mem_req,
    output logic              o_mem_we,
    output cache_pkg::word_t  o_mem_wdata,
    output logic [3:0]        o_mem_mask,
    output logic              o_ack,
    output cache_pkg::word_t  o_rdata
);

    cache_pkg::fsm_state_t r_state;
    logic                  r_req;         // registered i_req
    cache_pkg::tag_t       w_tag;
    cache_pkg::word_t      w_merged;      // write hit word
    cache_pkg::word_t      w_ldata;       // data field of the line write
    logic                  w_fill;        // read miss data returned

    assign w_tag    = i_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign w_merged = cache_pkg::merge_bytes(i_cword, i_wdata, i_mask);
    assign w_fill   = (r_state == cache_pkg::FILL) && o_mem_req && i_mem_ack;

    // write hit updates in LOOKUP, miss fill at memory ack, no write allocate
    assign o_line_we = ((r_state == cache_pkg::LOOKUP) && i_we && i_hit) || w_fill;
    assign w_ldata   = (r_state == cache_pkg::FILL) ? i_mem_rdata : w_merged;
    assign o_wline   = '{valid: 1'b1, tag: w_tag, data: w_ldata};

    always_ff @(posedge CLK or negedge rst_x) begin
        if (!rst_x) begin
            r_req     <= 1'b0;
            r_state   <= cache_pkg::IDLE;
            o_mem_req <= 1'b0;
            o_mem_we  <= 1'b0;
            o_ack     <= 1'b0;
        end else begin
            r_req <= i_req;
            case (r_state)
                cache_pkg::IDLE: begin
                    if (r_req) begin
                        r_state <= cache_pkg::LOOKUP;     // one cycle after sampling
                    end
                end
                cache_pkg::LOOKUP: begin
                    if (!i_we && i_hit) begin
                        r_state <= cache_pkg::DONE;       // read hit
                        o_ack   <= 1'b1;
                    end else begin
                        r_state   <= i_we ? cache_pkg::WRITE : cache_pkg::FILL;
                        o_mem_req <= 1'b1;
                        o_mem_we  <= i_we;
                    end
                end
                cache_pkg::FILL, cache_pkg::WRITE: begin
                    if (o_mem_req) begin
                        if (i_mem_ack) begin
                            o_mem_req <= 1'b0;            // release memory
                        end
                    end else begin
                        r_state <= cache_pkg::DONE;
                        o_ack   <= 1'b1;
                    end
                end
                cache_pkg::DONE: begin
                    if (!r_req) begin
                        r_state <= cache_pkg::IDLE;       // ack drops after release
                        o_ack   <= 1'b0;
                    end
                end
                default: r_state <= cache_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (r_state == cache_pkg::LOOKUP) begin
            o_mem_wdata <= i_wdata;           // write through payload
            o_mem_mask  <= i_mask;
            if (!i_we) begin
                o_rdata <= i_cword;           // hit word, replaced on a miss
            end
        end
        if (w_fill) begin
            o_rdata <= i_mem_rdata;           // miss word from memory
        end
    end

endmodule

// ==== hw/cache_top.sv ====
// top level with controller FSM, cache array and backing memory
`timescale 1ns/1ps

module cache_top (
    input  logic             CLK,
    input  logic             rst_x,
    input  logic             i_req,      // four phase with o_ack
    input  logic             i_we,
    input  cache_pkg::addr_t i_addr,     // word address
    input  cache_pkg::word_t i_wdata,
    input  logic [3:0]       i_mask,     // byte enables
    output logic             o_ack,
    output cache_pkg::word_t o_rdata     // valid with o_ack on reads
);

    logic             hit;
    cache_pkg::word_t cword;
    logic             line_we;
    cache_pkg::line_t wline;
    logic             mem_req;
    logic             mem_we;
    cache_pkg::word_t mem_wdata;
    logic [3:0]       mem_mask;
    logic             mem_ack;
    cache_pkg::word_t mem_rdata;

    cache_fsm u_fsm (
        .CLK         (CLK),
        .rst_x       (rst_x),
        .i_req       (i_req),
        .i_we        (i_we),
        .i_addr      (i_addr),
        .i_wdata     (i_wdata),
        .i_mask      (i_mask),
        .i_hit       (hit),
        .i_cword     (cword),
        .i_mem_ack   (mem_ack),
        .i_mem_rdata (mem_rdata),
        .o_line_we   (line_we),
        .o_wline     (wline),
        .o_mem_req   (mem_req),
        .o_mem_we    (mem_we),
        .o_mem_wdata (mem_wdata),
        .o_mem_mask  (mem_mask),
        .o_ack       (o_ack),
        .o_rdata     (o_rdata)
    );

    // index and tag come straight from the held request address
    line_lookup u_lookup (
        .CLK     (CLK),
        .rst_x   (rst_x),
        .i_addr  (i_addr),
        .i_we    (line_we),
        .i_wline (wline),
        .o_hit   (hit),
        .o_rdata (cword)
    );

    backing_mem u_mem (
        .CLK     (CLK),
        .rst_x   (rst_x),
        .i_req   (mem_req),
        .i_we    (mem_we),
        .i_addr  (i_addr),      // same word address as the request
        .i_wdata (mem_wdata),
        .i_mask  (mem_mask),
        .o_ack   (mem_ack),
        .o_rdata (mem_rdata)
    );

endmodule

// ==== bench/cache_properties.sv ====
// bound assertions on the requester handshake, access latencies and response data
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_properties (
    input logic             CLK,
    input logic             rst_x,
    input logic             i_req,
    input logic             i_we,
    input logic             o_ack,
    input logic             hit,       // cache array compare
    input logic             mem_req,   // internal memory handshake
    input logic             mem_ack,
    input cache_pkg::word_t o_rdata
);

    localparam int HIT_DLY  = 3;                  // ack set at edge 2 and seen at edge 3
    localparam int MISS_DLY = `MEM_LATENCY + 6;   // ack set at edge MEM_LATENCY+5
    localparam int MEM_DLY  = `MEM_LATENCY + 1;   // mem_req to mem_ack

    int fail_cnt = 0;                             // read by the testbench at the end

    ack_needs_req: assert property (@(posedge CLK) disable iff (!rst_x)
        $rose(o_ack) |-> $past(i_req))
        else begin $error("o_ack rose without i_req"); fail_cnt++; end

    ack_held: assert property (@(posedge CLK) disable iff (!rst_x)
        o_ack && i_req |=> o_ack)
        else begin $error("o_ack dropped while i_req high"); fail_cnt++; end

    ack_drop_after_req: assert property (@(posedge CLK) disable iff (!rst_x)
        $fell(o_ack) |-> !$past(i_req))
        else begin $error("o_ack fell before i_req"); fail_cnt++; end

    release_time: assert property (@(posedge CLK) disable iff (!rst_x)
        $fell(i_req) && o_ack |-> ##2 $fell(o_ack))
        else begin $error("o_ack release timing wrong"); fail_cnt++; end

    read_hit_time: assert property (@(posedge CLK) disable iff (!rst_x)
        $rose(i_req) && !i_we && hit |-> ##(HIT_DLY) $rose(o_ack))
        else begin $error("read hit latency wrong"); fail_cnt++; end

    mem_path_time: assert property (@(posedge CLK) disable iff (!rst_x)
        $rose(i_req) && (i_we || !hit) |-> ##(MISS_DLY) $rose(o_ack))
        else begin $error("miss or write latency wrong"); fail_cnt++; end

    mem_time: assert property (@(posedge CLK) disable iff (!rst_x)
        $rose(mem_req) |-> ##(MEM_DLY) $rose(mem_ack))
        else begin $error("backing memory latency wrong"); fail_cnt++; end

    rdata_hold: assert property (@(posedge CLK) disable iff (!rst_x)
        o_ack && $past(o_ack) |-> $stable(o_rdata))
        else begin $error("o_rdata changed during ack"); fail_cnt++; end

endmodule

bind cache_top cache_properties u_props (
    .CLK     (CLK),
    .rst_x   (rst_x),
    .i_req   (i_req),
    .i_we    (i_we),
    .o_ack   (o_ack),
    .hit     (hit),
    .mem_req (mem_req),
    .mem_ack (mem_ack),
    .o_rdata (o_rdata)
);

// ==== bench/tb_cache_top.sv ====
// testbench with clock, reset, shadow memory, cache tag model, directed and random tests
`timescale 1ns/1ps
`include "cache_consts.svh"

module tb_cache_top;

    localparam int DEPTH    = 2 ** `CACHE_ADDR_W;
    localparam int LINES    = 2 ** `CACHE_IDX_W;
    localparam int HIT_CYC  = 3;                    // LOOKUP at edge 1, ack at edge 2
    localparam int MISS_CYC = `MEM_LATENCY + 6;     // memory round trip, fill, DONE
    localparam int REL_CYC  = 2;                    // i_req seen low, then o_ack drops
    localparam int N_ACC    = 250;                  // upper bound on accesses, all tests
    localparam int MAX_CYC  = 16 + N_ACC * (MISS_CYC + REL_CYC + 4);  // about 4000

    logic             CLK;
    logic             rst_x;
    logic             i_req;
    logic             i_we;
    cache_pkg::addr_t i_addr;
    cache_pkg::word_t i_wdata;
    logic [3:0]       i_mask;
    logic             o_ack;
    cache_pkg::word_t o_rdata;

    cache_pkg::word_t shadow [DEPTH];     // expected memory words
    logic             ref_valid [LINES];  // expected cache line state
    cache_pkg::tag_t  ref_tag [LINES];
    int               errors = 0;
    int               checks = 0;
    int               tests = 0;
    int               cyc = 0;

    cache_top DUT (
        .CLK     (CLK),
        .rst_x   (rst_x),
        .i_req   (i_req),
        .i_we    (i_we),
        .i_addr  (i_addr),
        .i_wdata (i_wdata),
        .i_mask  (i_mask),
        .o_ack   (o_ack),
        .o_rdata (o_rdata)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;              // 10 ns period
    end

    initial begin : watchdog
        while (cyc < MAX_CYC) begin
            @(posedge CLK);
            cyc++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYC);
        $display("test failed");
        $finish;
    end

    // one bit per byte lane widened to a word
    function automatic logic [31:0] lane_bits(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    // one request through the four phase handshake, checked against both models
    task automatic access(input logic we, input cache_pkg::addr_t addr,
                          input cache_pkg::word_t wdata, input logic [3:0] mask,
                          input int hold);
        logic [`CACHE_IDX_W-1:0] idx;
        cache_pkg::tag_t         tag;
        cache_pkg::word_t        exp_data;
        int                      exp_lat;
        int                      lat;
        int                      rel;
        idx = addr[`CACHE_IDX_W-1:0];
        tag = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
        exp_lat = (!we && ref_valid[idx] && ref_tag[idx] == tag) ? HIT_CYC : MISS_CYC;
        if (we) begin
            shadow[addr] = (shadow[addr] & ~lane_bits(mask)) | (wdata & lane_bits(mask));
        end else begin
            ref_valid[idx] = 1'b1;            // reads fill, writes never allocate
            ref_tag[idx]   = tag;
        end
        exp_data = shadow[addr];
        i_we    = we;
        i_addr  = addr;
        i_wdata = wdata;
        i_mask  = mask;
        i_req   = 1'b1;
        lat = 0;
        do begin
            @(posedge CLK);
            #1 lat++;
        end while (!o_ack);
        checks++;
        assert (lat == exp_lat) else begin
            $display("error: o_ack latency at addr %h is %0h, expected %0h", addr, lat, exp_lat);
            errors++;
        end
        if (!we) begin
            assert (o_rdata === exp_data) else begin
                $display("error: o_rdata at addr %h is %h, expected %h", addr, o_rdata, exp_data);
                errors++;
            end
        end
        repeat (hold) begin                   // requester keeps i_req up
            @(posedge CLK);
            #1;
            assert (o_ack) else begin
                $display("o_ack dropped while i_req was still held at addr %h", addr);
                errors++;
            end
        end
        i_req = 1'b0;
        rel = 0;
        do begin
            @(posedge CLK);
            #1 rel++;
        end while (o_ack);
        assert (rel == REL_CYC) else begin
            $display("error: o_ack release took %0h cycles, expected %0h", rel, REL_CYC);
            errors++;
        end
    endtask

    task automatic report(input string name, input int err_start);
        tests++;
        if (errors == err_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - err_start);
        end
    endtask

    initial begin : stimulus
        cache_pkg::addr_t a;
        logic             we;
        int               e0;
        void'($urandom(84913));
        rst_x   = 1'b0;
        i_req   = 1'b0;
        i_we    = 1'b0;
        i_addr  = '0;
        i_wdata = '0;
        i_mask  = '0;
        for (int i = 0; i < DEPTH; i++) begin
            shadow[i] = '0;                   // backing memory starts zeroed
        end
        for (int i = 0; i < LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_tag[i]   = '0;
        end
        repeat (16) @(posedge CLK);           // covers the line clear sweep
        #1 rst_x = 1'b1;

        e0 = errors;
        assert (!o_ack) else begin
            $display("o_ack is high right after reset");
            errors++;
        end
        access(1'b0, 12'h000, '0, 4'h0, 0);   // distinct indexes, all misses
        access(1'b0, 12'h3a7, '0, 4'h0, 0);
        access(1'b0, 12'hfff, '0, 4'h0, 0);
        access(1'b0, 12'h512, '0, 4'h0, 0);
        report("reset reads", e0);

        e0 = errors;
        access(1'b1, 12'h2c4, 32'hdeadbeef, 4'hf, 0);
        access(1'b0, 12'h2c4, '0, 4'h0, 0);   // miss after no allocate
        access(1'b0, 12'h2c4, '0, 4'h0, 0);   // now a hit
        report("write then read", e0);

        e0 = errors;
        access(1'b1, 12'h2c4, 32'h11223344, 4'b0101, 0);  // cached word
        access(1'b0, 12'h2c4, '0, 4'h0, 0);
        access(1'b1, 12'h0a9, 32'h55667788, 4'b1010, 0);  // uncached word
        access(1'b1, 12'h0a9, 32'h99aabbcc, 4'b0001, 0);
        access(1'b0, 12'h0a9, '0, 4'h0, 0);
        access(1'b1, 12'h2c4, 32'hffeeddcc, 4'b1000, 0);
        access(1'b0, 12'h2c4, '0, 4'h0, 0);
        report("byte masks", e0);

        e0 = errors;
        access(1'b1, 12'h13b, 32'ha5a5c3c3, 4'hf, 0);     // same index b, two tags
        access(1'b1, 12'h7cb, 32'h5a5a3c3c, 4'hf, 0);
        repeat (3) begin
            access(1'b0, 12'h13b, '0, 4'h0, 0);           // evicts the other tag
            access(1'b0, 12'h7cb, '0, 4'h0, 0);
        end
        report("index conflict", e0);

        e0 = errors;
        repeat (200) begin
            a  = cache_pkg::addr_t'($urandom_range(0, 95));  // few tags so lines get reused
            we = 1'($urandom_range(0, 1));
            access(we, a, $urandom, 4'($urandom), 0);
        end
        report("random mix", e0);

        e0 = errors;
        access(1'b0, 12'h013, '0, 4'h0, 5);
        access(1'b1, 12'h013, 32'h0badf00d, 4'b0110, 3);
        access(1'b0, 12'h013, '0, 4'h0, 4);
        report("held request", e0);

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, checks, errors, DUT.u_props.fail_cnt);
        if (errors == 0 && DUT.u_props.fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+hw
hw/cache_pkg.sv
hw/word_ram.sv
hw/line_lookup.sv
hw/mem_wait_timer.sv
hw/backing_mem.sv
hw/cache_fsm.sv
hw/cache_top.sv
bench/cache_properties.sv
bench/tb_cache_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cache testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_cache_top -f project.f -o sim_cache

# assertion errors are counted by the testbench, so the run goes on to its verdict
./obj_dir/sim_cache +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "^test passed$" sim.log; then
    echo "simulation PASS"
    exit 0
else
    echo "simulation FAIL"
    exit 1
fi
